/* all.f */
hdl/cache_pkg.sv
hdl/bus_pkg.sv
hdl/cache_array.sv
hdl/cache_datapath.sv
hdl/cache_control.sv
hdl/apb_cache_port.sv
hdl/cache_top.sv
verif/pmem_model.sv
verif/cache_tb.sv

/* run.sh */
#!/bin/sh
# Build the cache testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module cache_tb -o cache_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cache_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$log"; then
    exit 1
fi
if ! grep -q "All checks passed" "$log"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* verif/cache_tb.sv */
// Testbench for the APB cache with clock, reset, APB tasks, shadow memory, checks and watchdog.
`timescale 1ns/1ns

module cache_tb
    import cache_pkg::*;
    import bus_pkg::*;
();

    localparam int clk_period  = 40;
    localparam int max_latency = 8;
    localparam int num_random  = 200;
    localparam int num_ops     = num_random + 20;   // Directed part stays under 20.

    logic      clk;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    pmem_req_t pmem_req;
    pmem_rsp_t pmem_rsp;

    logic [31:0] shadow [1024];         // Word image of memory as the cache should see it.
    apb_rsp_t    exp_q [$];
    pmem_req_t   wb_q [$];
    integer      seed = 57;
    int          access_cycles;         // Access cycles of the last APB transfer.

    cache_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .pmem_req (pmem_req),
        .pmem_rsp (pmem_rsp)
    );

    pmem_model i_pmem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (pmem_req),
        .rsp   (pmem_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int idx, input int word);
        cache_addr_u a;
        a.flat     = '0;
        a.f.tag    = s_tag'(tag);
        a.f.index  = s_index'(idx);
        a.f.offset = s_offset'(word * 4);
        return a.flat;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        return shadow[addr[11:2]];
    endfunction

    function automatic logic [s_line-1:0] ref_line(input logic [31:0] addr);
        logic [s_line-1:0] line;
        for (int w = 0; w < 8; w++)
            line[32*w +: 32] = shadow[{addr[11:5], 3'(w)}];
        return line;
    endfunction

    task automatic check_word(input apb_rsp_t got, input apb_rsp_t exp);
        if (got.pslverr !== exp.pslverr)
            fail_run($sformatf("MISMATCH apb_rsp.pslverr got %h expected %h",
                               got.pslverr, exp.pslverr));
        if (got.prdata !== exp.prdata)
            fail_run($sformatf("MISMATCH apb_rsp.prdata got %h expected %h at paddr %h",
                               got.prdata, exp.prdata, apb_req.paddr));
    endtask

    task automatic check_pmem(input pmem_req_t got, input pmem_req_t exp);
        if ({got.read, got.write} !== {exp.read, exp.write})
            fail_run($sformatf("MISMATCH pmem_req.read/write got %h expected %h",
                               {got.read, got.write}, {exp.read, exp.write}));
        if (got.addr !== exp.addr)
            fail_run($sformatf("MISMATCH pmem_req.addr got %h expected %h",
                               got.addr, exp.addr));
        if (got.wdata !== exp.wdata)
            fail_run($sformatf("MISMATCH pmem_req.wdata got %h expected %h",
                               got.wdata, exp.wdata));
    endtask

    // Access phase runs until pready, then the bus goes idle.
    task automatic finish_transfer();
        apb_req.penable = 1'b1;
        access_cycles   = 1;
        while (!apb_rsp.pready)
        begin
            @(posedge clk);
            #2;
            access_cycles++;
        end
        @(posedge clk);
        #2;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        apb_req.pstrb   = strb;
        @(posedge clk);
        #2;
        finish_transfer();
        for (int b = 0; b < 4; b++)
            if (strb[b])
                shadow[addr[11:2]][8*b +: 8] = data[8*b +: 8];
    endtask

    task automatic apb_read(input logic [31:0] addr);
        apb_rsp_t exp;
        exp.pready  = 1'b1;
        exp.pslverr = 1'b0;
        exp.prdata  = ref_read(addr);
        exp_q.push_back(exp);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwdata  = '0;
        apb_req.pstrb   = '0;
        @(posedge clk);
        #2;
        finish_transfer();
    endtask

    // A read hit ends in its third access cycle.
    task automatic read_hit(input logic [31:0] addr);
        apb_read(addr);
        if (access_cycles != 3)
            fail_run($sformatf("read hit at paddr %h took %0d access cycles instead of 3",
                               addr, access_cycles));
    endtask

    task automatic expect_writeback(input logic [31:0] addr);
        pmem_req_t exp;
        exp.read  = 1'b0;
        exp.write = 1'b1;
        exp.addr  = {addr[31:5], 5'b00000};
        exp.wdata = ref_line(addr);
        if (wb_q.size() != 1)
            fail_run($sformatf("expected one memory writeback but saw %0d", wb_q.size()));
        check_pmem(wb_q.pop_front(), exp);
    endtask

    // Every completed APB transfer is checked here.
    always @(negedge clk)
    begin
        if (rst_n && apb_req.psel && apb_req.penable && apb_rsp.pready)
        begin
            if (apb_req.pwrite)
            begin
                if (apb_rsp.pslverr)
                    fail_run("pslverr went high on a write transfer");
            end
            else if (exp_q.size() == 0)
                fail_run("a read completed with no expected value queued");
            else
                check_word(apb_rsp, exp_q.pop_front());
        end
    end

    always @(negedge clk)
    begin
        if (pmem_rsp.resp && pmem_req.write)
            wb_q.push_back(pmem_req);
    end

    initial
    begin
        #(num_ops * 8 * max_latency * 2 * clk_period);
        fail_run("watchdog expired before the tests finished");
    end

    initial
    begin
        logic [s_line-1:0] line;
        logic [31:0]       addr;
        logic [31:0]       data;
        logic [3:0]        strb;

        apb_req = '0;
        rst_n   = 1'b0;
        for (int l = 0; l < 128; l++)
        begin
            for (int w = 0; w < 8; w++)
            begin
                shadow[10'(l * 8 + w)] = fill_word(32'(l * 32 + w * 4));
                line[32*w +: 32]       = shadow[10'(l * 8 + w)];
            end
            i_pmem.mem[l] <= line;
        end
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // Read back after write, both ways of set 0.
        apb_write(make_addr(0, 0, 1), 32'h1234_5678, 4'hf);
        read_hit(make_addr(0, 0, 1));
        apb_write(make_addr(1, 0, 7), 32'h8765_4321, 4'hf);
        read_hit(make_addr(1, 0, 7));
        apb_write(make_addr(0, 0, 0), 32'h0f1e_2d3c, 4'hf);
        read_hit(make_addr(0, 0, 0));

        // Byte enables merge into the stored word.
        apb_write(make_addr(7, 1, 2), 32'h1111_1111, 4'hf);
        apb_write(make_addr(7, 1, 2), 32'haabb_ccdd, 4'b0101);
        read_hit(make_addr(7, 1, 2));
        apb_write(make_addr(7, 1, 6), 32'h99aa_5533, 4'b1000);
        read_hit(make_addr(7, 1, 6));

        // Third tag in set 2 evicts the first one.
        wb_q.delete();
        apb_write(make_addr(1, 2, 3), 32'hdead_0001, 4'hf);
        apb_write(make_addr(2, 2, 5), 32'hdead_0002, 4'b0011);
        apb_write(make_addr(3, 2, 0), 32'hdead_0003, 4'hf);
        expect_writeback(make_addr(1, 2, 3));

        // A, B, A, C leaves B least recently used.
        wb_q.delete();
        apb_write(make_addr(4, 3, 1), 32'h4444_0004, 4'hf);
        apb_write(make_addr(5, 3, 4), 32'h5555_0005, 4'b1100);
        read_hit(make_addr(4, 3, 1));
        apb_write(make_addr(6, 3, 2), 32'h6666_0006, 4'hf);
        expect_writeback(make_addr(5, 3, 4));
        apb_read(make_addr(5, 3, 4));   // Refill of B.

        for (int i = 0; i < num_random; i++)
        begin
            addr = make_addr({$random(seed)} % 16, {$random(seed)} % 8, {$random(seed)} % 8);
            if ($random(seed) & 1)
            begin
                data = $random(seed);
                strb = 4'($random(seed));
                apb_write(addr, data, strb);
            end
            else
                apb_read(addr);
        end

        @(posedge clk);
        #2;
        if (exp_q.size() != 0)
            fail_run("some reads never completed");
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* verif/pmem_model.sv */
// Physical memory model with a flat line store and random 1 to 8 cycle response.
`timescale 1ns/1ns

module pmem_model
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  pmem_req_t req,
    output pmem_rsp_t rsp
);

    localparam int num_lines = 128;     // Tags 0 to 15 over all sets.

    logic [s_line-1:0] mem [num_lines];  // Loaded by the testbench before reset ends.
    logic              busy;
    int                wait_cnt;
    int                remaining;
    integer            seed = 57;

    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rsp      <= '0;
            busy     <= 1'b0;
            wait_cnt <= 0;
        end
        else if (rsp.resp)
        begin
            rsp.resp <= 1'b0;           // The strobe drops on this edge.
        end
        else if (req.read || req.write)
        begin
            // Cycles left until resp, counting from the strobe.
            remaining = busy ? wait_cnt : 1 + ({$random(seed)} % 8);
            if (remaining == 1)
            begin
                busy     <= 1'b0;
                rsp.resp <= 1'b1;
                if (req.write)
                    mem[req.addr[11:5]] <= req.wdata;
                else
                    rsp.rdata <= mem[req.addr[11:5]];
            end
            else
            begin
                busy     <= 1'b1;
                wait_cnt <= remaining - 1;
            end
        end
    end

endmodule

/* hdl/cache_top.sv */
// Cache top level: APB port, control FSM and datapath.
`timescale 1ns/1ns

module cache_top
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output pmem_req_t pmem_req,
    input  pmem_rsp_t pmem_rsp
);

    cache_req_t        req;
    logic              req_valid;
    logic              req_done;
    cache_ctrl_t       ctrl;
    cache_stat_t       stat;
    logic [s_line-1:0] rdata_line;

    apb_cache_port i_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .req        (req),
        .req_valid  (req_valid),
        .req_done   (req_done),
        .rdata_line (rdata_line)
    );

    cache_control i_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_write  (req.write),
        .stat       (stat),
        .pmem_resp  (pmem_rsp.resp),
        .ctrl       (ctrl),
        .pmem_read  (pmem_req.read),
        .pmem_write (pmem_req.write),
        .req_done   (req_done)
    );

    cache_datapath i_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .ctrl       (ctrl),
        .pmem_rdata (pmem_rsp.rdata),
        .stat       (stat),
        .rdata_line (rdata_line),
        .pmem_addr  (pmem_req.addr),
        .pmem_wdata (pmem_req.wdata)
    );

endmodule

/* hdl/apb_cache_port.sv */
// APB slave port turning word transfers into line requests for the cache.
`timescale 1ns/1ns

module apb_cache_port
    import cache_pkg::*;
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  apb_req_t          apb_req,
    output apb_rsp_t          apb_rsp,
    output cache_req_t        req,
    output logic              req_valid,
    input  logic              req_done,
    input  logic [s_line-1:0] rdata_line
);

    logic [2:0]  word_sel;
    logic        pready;
    logic [31:0] prdata;

    assign word_sel = apb_req.paddr[4:2];

    // Master holds the fields until pready, so the request is stable.
    always_comb
    begin
        req.read      = ~apb_req.pwrite;
        req.write     = apb_req.pwrite;
        req.addr.flat = {apb_req.paddr[31:2], 2'b00};
        req.wdata     = {(s_line/32){apb_req.pwdata}};
        req.be        = s_mask'(apb_req.pstrb) << {word_sel, 2'b00};
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            req_valid <= 1'b0;
            pready    <= 1'b0;
        end
        else
        begin
            pready <= req_done;
            if (req_done)
                req_valid <= 1'b0;
            else if (apb_req.psel && !apb_req.penable)
                req_valid <= 1'b1;      // Setup phase seen.
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_done)
            prdata <= rdata_line[{word_sel, 5'b00000} +: 32];
    end

    assign apb_rsp.pready  = pready;
    assign apb_rsp.pslverr = 1'b0;
    assign apb_rsp.prdata  = prdata;

endmodule

/* hdl/cache_control.sv */
// Cache control FSM: compare, writeback, fill and respond.
`timescale 1ns/1ns

module cache_control
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    input  logic        req_write,
    input  cache_stat_t stat,
    input  logic        pmem_resp,
    output cache_ctrl_t ctrl,
    output logic        pmem_read,
    output logic        pmem_write,
    output logic        req_done
);

    typedef enum logic [1:0] {
        COMPARE,
        WRITEBACK,
        FILL,
        RESPOND
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= COMPARE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        ctrl       = '0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        req_done   = 1'b0;

        unique case (state)
            COMPARE:
            begin
                if (req_valid)
                begin
                    if (stat.hit)
                    begin
                        ctrl.set_lru = 1'b1;
                        if (req_write)
                        begin
                            ctrl.load_line = 1'b1;
                            ctrl.set_dirty = 1'b1;
                        end
                        state_next = RESPOND;
                    end
                    else if (stat.victim_dirty)
                        state_next = WRITEBACK;
                    else
                        state_next = FILL;
                end
            end
            WRITEBACK:
            begin
                pmem_write  = 1'b1;
                ctrl.wb_sel = 1'b1;   // Address of the evicted line.
                if (pmem_resp)
                    state_next = FILL;
            end
            FILL:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    ctrl.load_tag    = 1'b1;
                    ctrl.set_valid   = 1'b1;
                    ctrl.clear_dirty = 1'b1;
                    ctrl.load_line   = 1'b1;
                    ctrl.fill_sel    = 1'b1;
                    state_next       = COMPARE;     // Retry now hits.
                end
            end
            RESPOND:
            begin
                req_done   = 1'b1;
                state_next = COMPARE;
            end
            default:
            begin
                state_next = COMPARE;
            end
        endcase
    end

endmodule

/* hdl/cache_datapath.sv */
// Cache datapath: tag compare, way select, line merge, state arrays, memory address.
`timescale 1ns/1ns

module cache_datapath
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  cache_req_t        req,
    input  cache_ctrl_t       ctrl,
    input  logic [s_line-1:0] pmem_rdata,
    output cache_stat_t       stat,
    output logic [s_line-1:0] rdata_line,
    output logic [31:0]       pmem_addr,
    output logic [s_line-1:0] pmem_wdata
);

    logic [s_tag-1:0]   way_tag [2];
    logic               way_valid [2];
    logic               way_dirty [2];
    logic [s_line-1:0]  way_line [2];
    logic [1:0]         way_hit;
    logic               lru_way;        // Points at the least recently used way.
    logic               way_sel;
    logic [s_tag-1:0]   req_tag;
    logic [s_index-1:0] set_idx;
    logic [s_tag-1:0]   victim_tag;
    logic [s_line-1:0]  merged_line;
    logic [s_line-1:0]  line_in;
    cache_addr_u        line_addr;

    assign req_tag = req.addr.f.tag;
    assign set_idx = req.addr.f.index;

    assign way_hit[0] = way_valid[0] && (way_tag[0] == req_tag);
    assign way_hit[1] = way_valid[1] && (way_tag[1] == req_tag);

    // Hit way when there is one, otherwise the victim.
    assign way_sel = (way_hit != 2'b00) ? way_hit[1] : lru_way;

    assign stat.hit          = |way_hit;
    assign stat.victim_dirty = way_dirty[lru_way];

    assign rdata_line = way_line[way_sel];
    assign victim_tag = way_tag[lru_way];
    assign pmem_wdata = way_line[lru_way];

    // Store merges byte by byte over the current line.
    always_comb
    begin
        for (int b = 0; b < s_mask; b++)
        begin
            merged_line[8*b +: 8] = req.be[b] ? req.wdata[8*b +: 8] : rdata_line[8*b +: 8];
        end
    end

    assign line_in = ctrl.fill_sel ? pmem_rdata : merged_line;

    always_comb
    begin
        line_addr.f.tag    = ctrl.wb_sel ? victim_tag : req_tag;
        line_addr.f.index  = set_idx;
        line_addr.f.offset = '0;
    end

    assign pmem_addr = line_addr.flat;

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        logic sel;

        assign sel = (way_sel == 1'(w));

        cache_array #(.width(s_tag)) i_tag (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (ctrl.load_tag && sel),
            .index   (set_idx),
            .datain  (req_tag),
            .dataout (way_tag[w])
        );

        cache_array #(.width(1)) i_valid (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (ctrl.set_valid && sel),
            .index   (set_idx),
            .datain  (1'b1),
            .dataout (way_valid[w])
        );

        // Set on a write hit, cleared by a fill.
        cache_array #(.width(1)) i_dirty (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    ((ctrl.set_dirty || ctrl.clear_dirty) && sel),
            .index   (set_idx),
            .datain  (ctrl.set_dirty),
            .dataout (way_dirty[w])
        );

        cache_array #(.width(s_line)) i_data (
            .clk     (clk),
            .rst_n   (rst_n),
            .load    (ctrl.load_line && sel),
            .index   (set_idx),
            .datain  (line_in),
            .dataout (way_line[w])
        );
    end

    cache_array #(.width(1)) i_lru (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (ctrl.set_lru),
        .index   (set_idx),
        .datain  (~way_sel),              // The other way becomes LRU.
        .dataout (lru_way)
    );

endmodule

/* hdl/cache_array.sv */
// Per-set storage array with combinational read and clocked write.
`timescale 1ns/1ns

module cache_array
    import cache_pkg::*;
#(
    parameter int width = 1
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load,
    input  logic [s_index-1:0] index,
    input  logic [width-1:0]   datain,
    output logic [width-1:0]   dataout
);

    logic [width-1:0] data [num_sets];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < num_sets; i++)
                data[i] <= '0;
        end
        else if (load)
        begin
            data[index] <= datain;
        end
    end

    assign dataout = data[index];     // New contents show up the cycle after load.

endmodule

/* hdl/bus_pkg.sv */
// APB request/response and memory port request/response structs.
package bus_pkg;

    import cache_pkg::*;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // One line per transfer, address is line aligned.
    typedef struct packed {
        logic              read;
        logic              write;
        logic [31:0]       addr;
        logic [s_line-1:0] wdata;
    } pmem_req_t;

    typedef struct packed {
        logic              resp;
        logic [s_line-1:0] rdata;
    } pmem_rsp_t;

endpackage

/* hdl/cache_pkg.sv */
// Cache geometry, address union, FSM control strobes and datapath status.
package cache_pkg;

    localparam int s_offset = 5;        // Byte offset within a line.
    localparam int s_index  = 3;
    localparam int s_tag    = 24;
    localparam int num_sets = 8;
    localparam int s_line   = 256;
    localparam int s_mask   = 32;       // One enable per byte of the line.

    // Flat byte address, or the tag/index/offset split used by the datapath.
    typedef union packed {
        logic [31:0] flat;
        struct packed {
            logic [s_tag-1:0]    tag;
            logic [s_index-1:0]  index;
            logic [s_offset-1:0] offset;
        } f;
    } cache_addr_u;

    typedef struct packed {
        logic              read;
        logic              write;
        cache_addr_u       addr;
        logic [s_line-1:0] wdata;
        logic [s_mask-1:0] be;
    } cache_req_t;

    typedef struct packed {
        logic load_tag;
        logic set_valid;
        logic set_dirty;
        logic clear_dirty;
        logic load_line;
        logic fill_sel;     // Line comes from memory, not from the request.
        logic set_lru;
        logic wb_sel;       // Memory address built from the victim tag.
    } cache_ctrl_t;

    typedef struct packed {
        logic hit;
        logic victim_dirty;
    } cache_stat_t;

endpackage
